//--- ulpi_pkg.sv
// Fixed enumeration script for one device with no CRC checks and at most 64 steps
package ulpi_pkg;

	localparam int DATA_W = 8; // ULPI data bus width

	typedef logic [DATA_W-1:0] ulpi_byte_t;

	// PHY reset hold time in CLKOUT cycles
	localparam logic [31:0] PHY_RESET_CYCLES = 32'd1000000;

	// Link idle byte, also driven with STP
	localparam ulpi_byte_t TXCMD_NOOP = 8'h00;

	// Register write TXCMDs are 10 followed by the 6 bit address
	localparam ulpi_byte_t REG_WRITE_OTG_CTRL  = 8'h8A; // OTG_CTRL at 0x0A
	localparam ulpi_byte_t REG_WRITE_FUNC_CTRL = 8'h84; // FUNC_CTRL at 0x04

	// Transmit TXCMD 0100 with the ACK PID nibble
	localparam ulpi_byte_t TXCMD_ACK = 8'h42;

	typedef enum logic [1:0] {
		STEP_TX,    // Offer value on the transmit channel
		STEP_MATCH, // Wait for a received byte equal to value
		STEP_SKIP,  // Drop value received bytes
		STEP_END    // Script done
	} step_kind_e;

	typedef struct packed {
		step_kind_e kind;
		ulpi_byte_t value; // Byte to send or match, or skip count
		logic       last;  // Last byte of a transmit transfer
	} script_step_t;

	localparam int SCRIPT_LEN = 48;

	typedef logic [5:0] script_idx_t;

	localparam script_step_t ENUM_SCRIPT [SCRIPT_LEN] = '{
		// OTG off, peripheral mode
		'{STEP_TX, REG_WRITE_OTG_CTRL, 1'b0},
		'{STEP_TX, 8'h00, 1'b1},
		// Full speed, normal operation
		'{STEP_TX, REG_WRITE_FUNC_CTRL, 1'b0},
		'{STEP_TX, 8'h45, 1'b1},
		// DATA0 setup, GET_DESCRIPTOR for the device descriptor
		'{STEP_MATCH, 8'hC3, 1'b0},
		'{STEP_MATCH, 8'h80, 1'b0},
		'{STEP_MATCH, 8'h06, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h01, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h40, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_SKIP, 8'd2, 1'b0}, // CRC16
		'{STEP_TX, TXCMD_ACK, 1'b1},
		// IN token
		'{STEP_MATCH, 8'h69, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h10, 1'b0},
		// DATA1 with the first 8 descriptor bytes
		'{STEP_TX, 8'h4B, 1'b0},
		'{STEP_TX, 8'h12, 1'b0}, // bLength
		'{STEP_TX, 8'h01, 1'b0}, // bDescriptorType
		'{STEP_TX, 8'h00, 1'b0},
		'{STEP_TX, 8'h02, 1'b0}, // USB 2.0
		'{STEP_TX, 8'hFF, 1'b0},
		'{STEP_TX, 8'hFF, 1'b0},
		'{STEP_TX, 8'hFF, 1'b0},
		'{STEP_TX, 8'h08, 1'b0}, // bMaxPacketSize0
		'{STEP_TX, 8'h16, 1'b0}, // CRC16, low byte first
		'{STEP_TX, 8'h33, 1'b1},
		// OUT token, then zero length DATA1 status
		'{STEP_MATCH, 8'hE1, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h10, 1'b0},
		'{STEP_MATCH, 8'h4B, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_TX, TXCMD_ACK, 1'b1},
		// Second setup, SET_ADDRESS 3
		'{STEP_MATCH, 8'hC3, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h05, 1'b0},
		'{STEP_MATCH, 8'h03, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_MATCH, 8'h00, 1'b0},
		'{STEP_SKIP, 8'd2, 1'b0}, // CRC16
		'{STEP_TX, TXCMD_ACK, 1'b1},
		'{STEP_END, 8'h00, 1'b0}
	};

endpackage

//--- ulpi_tx_if.sv
// A byte moves only on an edge with valid and ready high and the source must hold its values until then
interface ulpi_tx_if ();

	logic                 valid;   // Byte offered
	logic                 ready;   // Engine takes it this edge
	ulpi_pkg::ulpi_byte_t tx_byte;
	logic                 last;    // Closes the transfer with STP

	// Script side
	modport source (
		output valid,
		output tx_byte,
		output last,
		input  ready
	);

	// Bus side
	modport sink (
		input  valid,
		input  tx_byte,
		input  last,
		output ready
	);

endinterface

//--- phy_reset_ctrl.sv
// RESET_CYCLES must be at least 1 and the PHY reset is released only once per link reset
module phy_reset_ctrl #(
	parameter logic [31:0] RESET_CYCLES = ulpi_pkg::PHY_RESET_CYCLES
) (
	input  logic CLKOUT,
	input  logic reset,     // Synchronous, active low
	output logic phy_rst,   // Active high to the PHY
	output logic phy_ready  // Level, high once the PHY is out of reset
);

	logic [31:0] rst_count;
	logic        rst_done; // One-shot flag

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			rst_count <= '0;
			rst_done  <= 1'b0;
			phy_rst   <= 1'b1; // Hold PHY in reset
		end
		else if (!rst_done)
		begin
			// Release on the RESET_CYCLES-th edge after reset goes high
			if (rst_count == RESET_CYCLES - 32'd1)
			begin
				rst_done <= 1'b1;
				phy_rst  <= 1'b0;
			end
			else
			begin
				rst_count <= rst_count + 32'd1;
			end
		end
		// Counter parks once done
	end

	assign phy_ready = rst_done;

endmodule

//--- ulpi_rx_capture.sv
// Packet data bytes only with no RXCMD decoding so line state and receive errors are not seen
module ulpi_rx_capture (
	input  logic                 CLKOUT,
	input  logic                 reset,
	input  logic                 dir,
	input  logic                 nxt,
	input  ulpi_pkg::ulpi_byte_t bus_in,   // Raw data bus
	output logic                 rx_valid, // One cycle per received byte
	output ulpi_pkg::ulpi_byte_t rx_byte
);

	logic dir_q;       // dir one cycle back
	logic rx_data_cyc; // Real receive data on the bus

	// Turnaround is the first dir high cycle
	// dir high with nxt low carries an RXCMD
	assign rx_data_cyc = dir && dir_q && nxt;

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			dir_q    <= 1'b0;
			rx_valid <= 1'b0;
		end
		else
		begin
			dir_q    <= dir;
			rx_valid <= rx_data_cyc;
		end
	end

	// Byte register, only meaningful with rx_valid
	always_ff @(posedge CLKOUT)
	begin
		if (rx_data_cyc)
		begin
			rx_byte <= bus_in;
		end
	end

endmodule

//--- ulpi_tx_engine.sv
// The source must keep each transfer back to back and a transfer aborted by the PHY is not retried
module ulpi_tx_engine (
	input  logic                 CLKOUT,
	input  logic                 reset,
	input  logic                 dir,
	input  logic                 nxt,
	ulpi_tx_if.sink              tx,
	output ulpi_pkg::ulpi_byte_t bus_out, // Link side of the data bus
	output logic                 stp
);

	typedef enum logic [1:0] {
		IDLE,      // Nothing held
		WAIT_LINE, // Byte held, waiting for a free bus
		SEND,      // Held byte on the bus
		STOP       // 00 with STP for one cycle
	} tx_state_e;

	tx_state_e            state;
	ulpi_pkg::ulpi_byte_t hold_byte; // Byte on the bus in SEND
	logic                 hold_last;
	logic                 hold_full;
	logic                 accept;    // PHY takes the bus byte this edge
	logic                 load;      // Holding register fills this edge

	// dir high means the PHY owns the bus, nxt is then not ours
	assign accept = (state == SEND) && !dir && nxt;

	// Next byte moves in while the current one is taken
	assign tx.ready = !hold_full || accept;
	assign load     = tx.valid && tx.ready;

	assign bus_out = (state == SEND) ? hold_byte : ulpi_pkg::TXCMD_NOOP;
	assign stp     = (state == STOP);

	always_ff @(posedge CLKOUT)
	begin
		if (load)
		begin
			hold_byte <= tx.tx_byte;
			hold_last <= tx.last;
		end
	end

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			state     <= IDLE;
			hold_full <= 1'b0;
		end
		else
		begin
			if (load)
				hold_full <= 1'b1;
			else if (accept)
				hold_full <= 1'b0;

			case (state)
				IDLE:
				begin
					if (hold_full || load)
						state <= WAIT_LINE;
				end
				WAIT_LINE:
				begin
					// First byte only on an idle bus
					if (!dir && !nxt)
						state <= SEND;
				end
				SEND:
				begin
					// hold_last still refers to the byte being taken
					if (accept && hold_last)
						state <= STOP;
				end
				STOP:
				begin
					state <= IDLE; // Single STP cycle
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

//--- enum_sequencer.sv
// Runs the package script once per reset and a byte that does not match is dropped without leaving the step
module enum_sequencer (
	input  logic                 CLKOUT,
	input  logic                 reset,
	input  logic                 phy_ready,
	input  logic                 rx_valid,
	input  ulpi_pkg::ulpi_byte_t rx_byte,
	ulpi_tx_if.source            tx,
	output logic                 seq_done
);

	ulpi_pkg::script_idx_t  step_idx;   // Current script step
	ulpi_pkg::script_step_t cur_step;
	ulpi_pkg::ulpi_byte_t   skip_count; // Bytes dropped in a skip step
	logic                   running;

	assign cur_step = ulpi_pkg::ENUM_SCRIPT[step_idx];

	// Transmit steps offer their byte directly
	assign tx.valid   = running && (cur_step.kind == ulpi_pkg::STEP_TX);
	assign tx.tx_byte = cur_step.value;
	assign tx.last    = cur_step.last;

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			running    <= 1'b0;
			step_idx   <= '0;
			skip_count <= '0;
			seq_done   <= 1'b0;
		end
		else if (!running)
		begin
			// Script begins the cycle after phy_ready
			if (phy_ready)
				running <= 1'b1;
		end
		else
		begin
			case (cur_step.kind)
				ulpi_pkg::STEP_MATCH:
				begin
					if (rx_valid && (rx_byte == cur_step.value))
						step_idx <= step_idx + 1'b1;
				end
				ulpi_pkg::STEP_SKIP:
				begin
					if (rx_valid)
					begin
						// Count held in the value field
						if (skip_count == cur_step.value - 8'd1)
						begin
							skip_count <= '0;
							step_idx   <= step_idx + 1'b1;
						end
						else
						begin
							skip_count <= skip_count + 8'd1;
						end
					end
				end
				ulpi_pkg::STEP_TX:
				begin
					if (tx.valid && tx.ready)
						step_idx <= step_idx + 1'b1;
				end
				ulpi_pkg::STEP_END:
				begin
					seq_done <= 1'b1; // Pointer parks here
				end
				default:
				begin
					seq_done <= 1'b1;
				end
			endcase
		end
	end

endmodule

//--- ulpi_link_top.sv
// Single ULPI PHY in peripheral mode and the data bus is driven only while dir is low
module ulpi_link_top #(
	parameter logic [31:0] RESET_CYCLES = ulpi_pkg::PHY_RESET_CYCLES
) (
	input  logic                          CLKOUT,   // 60 MHz from the PHY
	input  logic                          reset,    // Synchronous, active low
	input  logic                          dir,
	input  logic                          nxt,
	inout  wire  [ulpi_pkg::DATA_W-1:0]   data,     // Shared ULPI bus
	output logic                          stp,
	output logic                          phy_rst,  // Active high
	output logic                          seq_done
);

	ulpi_pkg::ulpi_byte_t bus_out;   // Link drive value
	ulpi_pkg::ulpi_byte_t bus_in;    // Bus as seen by the link
	ulpi_pkg::ulpi_byte_t rx_byte;
	logic                 rx_valid;
	logic                 phy_ready;

	ulpi_tx_if tx_ch ();

	// PHY owns the bus while dir is high
	assign data   = dir ? 'z : bus_out;
	assign bus_in = data;

	phy_reset_ctrl #(
		.RESET_CYCLES (RESET_CYCLES)
	) u_phy_reset_ctrl (
		.CLKOUT    (CLKOUT),
		.reset     (reset),
		.phy_rst   (phy_rst),
		.phy_ready (phy_ready)
	);

	ulpi_rx_capture u_ulpi_rx_capture (
		.CLKOUT   (CLKOUT),
		.reset    (reset),
		.dir      (dir),
		.nxt      (nxt),
		.bus_in   (bus_in),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	ulpi_tx_engine u_ulpi_tx_engine (
		.CLKOUT  (CLKOUT),
		.reset   (reset),
		.dir     (dir),
		.nxt     (nxt),
		.tx      (tx_ch.sink),
		.bus_out (bus_out),
		.stp     (stp)
	);

	enum_sequencer u_enum_sequencer (
		.CLKOUT    (CLKOUT),
		.reset     (reset),
		.phy_ready (phy_ready),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.tx        (tx_ch.source),
		.seq_done  (seq_done)
	);

endmodule

//--- tb_checker.sv
// Checks the fixed enumeration run with RESET_CYCLES 64 and six transfers and counts errors for the top
module tb_checker (
	input logic       CLKOUT,
	input logic       reset,
	input logic       dir,
	input logic       nxt,
	input logic [7:0] data,
	input logic       stp,
	input logic       phy_rst,
	input logic       seq_done
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES  = 64;
	localparam int NUM_TRANSFERS = 6; // Two register writes, three ACKs, one descriptor

	int         error_count = 0;
	int         byte_count  = 0;
	int         stp_count   = 0;
	int         high_cycles = 0;
	logic [8:0] exp_q [$];  // {last, byte} from the PHY model
	logic       released  = 1'b0;
	logic       in_tx     = 1'b0; // Transfer on the bus
	logic       held      = 1'b0; // Byte on the bus waiting for nxt
	logic [7:0] held_byte;
	logic       want_stp  = 1'b0;
	logic       stp_due;
	logic       done_due  = 1'b0;

	task add_expected(input logic [7:0] b, input logic last);
		exp_q.push_back({last, b});
	endtask

	task compare_byte(input logic [7:0] got);
		logic [8:0] exp;
		byte_count++;
		if (exp_q.size() == 0)
		begin
			$display("Transmit byte %02h accepted with nothing expected", got);
			error_count++;
		end
		else
		begin
			exp = exp_q.pop_front();
			if (got !== exp[7:0])
			begin
				$display("[ERROR] data: expected %02h, got %02h", exp[7:0], got);
				error_count++;
			end
			want_stp = exp[8]; // Last byte of its group
		end
	endtask

	task final_check();
		if (exp_q.size() != 0)
		begin
			$display("%0d expected transmit bytes were never sent", exp_q.size());
			error_count++;
		end
		if (stp_count != NUM_TRANSFERS)
		begin
			$display("Saw %0d stp pulses instead of %0d", stp_count, NUM_TRANSFERS);
			error_count++;
		end
	endtask

	always @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			released = 1'b0;
			high_cycles = 0;
			in_tx = 1'b0;
			held = 1'b0;
			want_stp = 1'b0;
			done_due = 1'b0;
		end
		else
		begin
			if (!released)
			begin
				if (phy_rst)
					high_cycles++; // Pre-edge value
				else
				begin
					released = 1'b1;
					if (high_cycles != RESET_CYCLES)
					begin
						$display("[ERROR] phy_rst cycles: expected %0h, got %0h",
							RESET_CYCLES, high_cycles);
						error_count++;
					end
				end
			end
			else if (phy_rst)
			begin
				$display("phy_rst rose again after its release");
				error_count++;
			end
			if (phy_rst && (data !== 8'h00 || stp !== 1'b0))
			begin
				$display("[ERROR] data/stp in PHY reset: expected 00/0, got %02h/%0h", data, stp);
				error_count++;
			end
			if (dir && $isunknown(data))
			begin
				$display("Data bus unknown while the PHY owns it");
				error_count++;
			end
			if (done_due)
			begin
				done_due = 1'b0;
				if (seq_done !== 1'b1)
				begin
					$display("[ERROR] seq_done: expected 1, got %0h", seq_done);
					error_count++;
				end
			end
			// Last ACK is handed over only after the second setup packet
			else if (seq_done && stp_count < NUM_TRANSFERS - 1)
			begin
				$display("seq_done rose before the last transfer");
				error_count++;
			end
			stp_due = want_stp; // Set by last accepted byte one edge back
			want_stp = 1'b0;
			if (stp !== stp_due)
			begin
				$display("[ERROR] stp: expected %0h, got %0h", stp_due, stp);
				error_count++;
			end
			if (stp)
			begin
				if (data !== 8'h00)
				begin
					$display("[ERROR] data with stp: expected 00, got %02h", data);
					error_count++;
				end
				stp_count++;
				in_tx = 1'b0;
				held = 1'b0;
				if (stp_count == NUM_TRANSFERS)
					done_due = 1'b1;
			end
			else if (!dir)
			begin
				if (!in_tx && data !== 8'h00)
				begin
					in_tx = 1'b1; // First byte is never 00
					if (exp_q.size() == 0)
					begin
						$display("Transmit started with no transfer expected");
						error_count++;
					end
				end
				if (in_tx)
				begin
					if (held && data !== held_byte)
					begin
						$display("[ERROR] data while nxt low: expected %02h, got %02h",
							held_byte, data);
						error_count++;
					end
					if (nxt)
					begin
						compare_byte(data);
						held = 1'b0;
					end
					else
					begin
						held = 1'b1;
						held_byte = data;
					end
				end
			end
		end
	end

endmodule

//--- tb_ulpi_link.sv
// PHY model for one fixed enumeration with RESET_CYCLES 64 and random gaps, RXCMDs, noise and stalls
module tb_ulpi_link;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 64;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + 4000) * 20;
	localparam logic [7:0] DESC [11] = '{8'h4B, 8'h12, 8'h01, 8'h00, 8'h02,
		8'hFF, 8'hFF, 8'hFF, 8'h08, 8'h16, 8'h33};

	logic       CLKOUT = 1'b0;
	logic       reset  = 1'b0;
	logic       dir    = 1'b0;
	logic       nxt    = 1'b0;
	logic [7:0] phy_data = 8'h00;
	logic [7:0] lfsr = 8'd58;
	logic [7:0] pkt_q [$];   // Receive packet being sent
	wire  [7:0] data;
	wire        stp;
	wire        phy_rst;
	wire        seq_done;

	assign data = dir ? phy_data : 8'hzz; // PHY side of the bus

	always #10 CLKOUT = !CLKOUT;

	ulpi_link_top #(
		.RESET_CYCLES (RESET_CYCLES)
	) u_ulpi_link_top (
		.CLKOUT   (CLKOUT),
		.reset    (reset),
		.dir      (dir),
		.nxt      (nxt),
		.data     (data),
		.stp      (stp),
		.phy_rst  (phy_rst),
		.seq_done (seq_done)
	);

	tb_checker u_checker (
		.CLKOUT   (CLKOUT),
		.reset    (reset),
		.dir      (dir),
		.nxt      (nxt),
		.data     (data),
		.stp      (stp),
		.phy_rst  (phy_rst),
		.seq_done (seq_done)
	);

	// Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1, one step per bit
	task get_bits(input int n, output logic [7:0] val);
		val = 8'h00;
		repeat (n)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
			val = {val[6:0], lfsr[0]};
		end
	endtask

	task drive_cycle(input logic d, input logic n, input logic [7:0] b);
		@(posedge CLKOUT);
		#2;
		dir = d;
		nxt = n;
		phy_data = b;
	endtask

	// Gap, turnaround, then pkt_q with RXCMDs and noise, then n_crc unchecked bytes
	task send_packet(input int n_crc);
		logic [7:0] r;
		logic [7:0] noise;
		get_bits(3, r);
		repeat (r)
			drive_cycle(1'b0, 1'b0, 8'h00);
		drive_cycle(1'b1, 1'b0, 8'h00); // Turnaround
		foreach (pkt_q[i])
		begin
			get_bits(2, r);
			if (r == 0)
			begin
				get_bits(8, noise);
				drive_cycle(1'b1, 1'b0, noise); // RXCMD
			end
			get_bits(2, r);
			if (r == 0)
			begin
				get_bits(8, noise);
				drive_cycle(1'b1, 1'b1, pkt_q[i] ^ (noise | 8'h01)); // Never matches
			end
			drive_cycle(1'b1, 1'b1, pkt_q[i]);
		end
		repeat (n_crc)
		begin
			get_bits(8, r);
			drive_cycle(1'b1, 1'b1, r);
		end
		drive_cycle(1'b0, 1'b0, 8'h00);
	endtask

	// Waits for a TXCMD, then accepts bytes with random stalls until stp
	task accept_transfer();
		logic [7:0] s;
		do
		begin
			@(posedge CLKOUT);
			#2;
		end
		while (data === 8'h00);
		forever
		begin
			get_bits(2, s);
			if (s != 0)
			begin
				nxt = 1'b0;
				repeat (s)
				begin
					@(posedge CLKOUT);
					#2;
				end
			end
			nxt = 1'b1;
			@(posedge CLKOUT);
			#2;
			if (stp)
			begin
				nxt = 1'b0;
				break;
			end
		end
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the enumeration did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		repeat (8)
			@(posedge CLKOUT);
		#2;
		reset = 1'b1;
		u_checker.add_expected(8'h8A, 1'b0);
		u_checker.add_expected(8'h00, 1'b1);
		u_checker.add_expected(8'h84, 1'b0);
		u_checker.add_expected(8'h45, 1'b1);
		accept_transfer();
		accept_transfer();
		pkt_q = '{8'hC3, 8'h80, 8'h06, 8'h00, 8'h01, 8'h00, 8'h00, 8'h40, 8'h00};
		send_packet(2);
		u_checker.add_expected(8'h42, 1'b1);
		accept_transfer();
		pkt_q = '{8'h69, 8'h00, 8'h10}; // IN token
		send_packet(0);
		foreach (DESC[i])
			u_checker.add_expected(DESC[i], i == 10);
		accept_transfer();
		pkt_q = '{8'hE1, 8'h00, 8'h10}; // OUT token
		send_packet(0);
		pkt_q = '{8'h4B, 8'h00, 8'h00}; // Zero length DATA1
		send_packet(0);
		u_checker.add_expected(8'h42, 1'b1);
		accept_transfer();
		pkt_q = '{8'hC3, 8'h00, 8'h05, 8'h03, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
		send_packet(2);
		u_checker.add_expected(8'h42, 1'b1);
		accept_transfer();
		repeat (20)
			@(posedge CLKOUT); // Watch for stray stp
		u_checker.final_check();
		$display("Done: %0d bytes, %0d stp pulses, %0d errors",
			u_checker.byte_count, u_checker.stp_count, u_checker.error_count);
		if (u_checker.error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- src.f
ulpi_pkg.sv
ulpi_tx_if.sv
phy_reset_ctrl.sv
ulpi_rx_capture.sv
ulpi_tx_engine.sv
enum_sequencer.sv
ulpi_link_top.sv
tb_checker.sv
tb_ulpi_link.sv
